// ==== design/control_consts.svh ====
`ifndef CONTROL_CONSTS_SVH
`define CONTROL_CONSTS_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// Opcodes
`define R_OPCODE 6'h00
`define OPC_ADDI 6'h08

// R-type funct codes
`define FUNCT_ADD 6'h20
`define FUNCT_AND 6'h24
`define FUNCT_SUB 6'h22

// Memory read cycles before the instruction latch
`define FETCH_WAIT_CYCLES 3

// Cycles the exception code is held before entry
`define EXCEPT_WAIT_CYCLES 4

// Wide enough for the longest wait
`define WAIT_CNT_W 3

`endif

// ==== design/control_pkg.sv ====
`include "control_consts.svh"

package control_pkg;

    typedef logic [`OPCODE_W-1:0] opcode_t;
    typedef logic [`FUNCT_W-1:0] funct_t;
    typedef logic [`WAIT_CNT_W-1:0] wait_cnt_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_AND,
        OP_SUB,
        OP_ADDI,
        OP_INVALID
    } decoded_op_t;

    typedef enum logic [3:0] {
        ST_FETCH,
        ST_LATCH,
        ST_DECODE,
        ST_EXEC_R,
        ST_EXEC_I,
        ST_WRITE_R,
        ST_WRITE_I,
        ST_EXC_OPCODE,
        ST_EXC_OVERFLOW,
        ST_EXC_ENTRY
    } ctrl_state_t;

    // Datapath select encodings
    typedef enum logic [2:0] {ALU_NOP = 3'd0, ALU_ADD = 3'd1, ALU_AND = 3'd2, ALU_SUB = 3'd3} alu_op_t;
    typedef enum logic [1:0] {SRC_A_PC = 2'd0, SRC_A_REG = 2'd1} alu_src_a_t;
    typedef enum logic [2:0] {
        SRC_B_REG = 3'd0, SRC_B_FOUR = 3'd1, SRC_B_IMM = 3'd2, SRC_B_BRANCH = 3'd3
    } alu_src_b_t;
    typedef enum logic [2:0] {ADDR_PC = 3'd0, ADDR_PC_HOLD = 3'd1, ADDR_EXC_VECTOR = 3'd2} iord_t;
    typedef enum logic [2:0] {PC_FROM_ALU = 3'd0, PC_FROM_EXC = 3'd3} pc_src_t;
    typedef enum logic [1:0] {DST_RT = 2'd0, DST_RD = 2'd1} reg_dst_t;
    typedef enum logic [3:0] {WB_ALU_OUT = 4'd0} mem_to_reg_t;
    typedef enum logic [1:0] {EXC_OPCODE = 2'd0, EXC_OVERFLOW = 2'd1} except_code_t;

    typedef struct packed {
        logic    pc_write;
        pc_src_t pc_src;
        logic    epc_write;
    } pc_ctrl_t;

    typedef struct packed {
        logic  mem_wr;
        iord_t iord;
        logic  ir_write;
    } mem_ctrl_t;

    typedef struct packed {
        logic       a_write;
        logic       b_write;
        alu_src_a_t alu_src_a;
        alu_src_b_t alu_src_b;
        alu_op_t    alu_op;
        logic       alu_out_write;
    } alu_ctrl_t;

    typedef struct packed {
        logic        reg_write;
        reg_dst_t    reg_dst;
        mem_to_reg_t mem_to_reg;
    } reg_ctrl_t;

endpackage

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ps
`include "control_consts.svh"

module instr_decoder (
    input  control_pkg::opcode_t     opcode,
    input  control_pkg::funct_t      funct,
    output control_pkg::decoded_op_t decoded_op
);

    import control_pkg::*;

    always_comb begin
        decoded_op = OP_INVALID;
        case (opcode)
            `R_OPCODE: begin
                // Only the three supported ALU functs
                case (funct)
                    `FUNCT_ADD: begin
                        decoded_op = OP_ADD;
                    end
                    `FUNCT_AND: begin
                        decoded_op = OP_AND;
                    end
                    `FUNCT_SUB: begin
                        decoded_op = OP_SUB;
                    end
                    default: begin
                        decoded_op = OP_INVALID;
                    end
                endcase
            end
            `OPC_ADDI: begin
                decoded_op = OP_ADDI;
            end
            default: begin
                decoded_op = OP_INVALID;
            end
        endcase
    end

endmodule

// ==== design/control_fsm.sv ====
`timescale 1ns/1ps
`include "control_consts.svh"

module control_fsm (
    input  logic                     clk,
    input  logic                     reset,
    input  control_pkg::decoded_op_t decoded_op,
    input  logic                     ov,
    output control_pkg::ctrl_state_t state
);

    import control_pkg::*;

    ctrl_state_t state_next;
    wait_cnt_t   wait_cnt;
    wait_cnt_t   wait_cnt_next;
    logic        in_wait;
    logic        fetch_done;
    logic        exc_done;

    assign in_wait = (state == ST_FETCH) || (state == ST_EXC_OPCODE) ||
                     (state == ST_EXC_OVERFLOW);
    assign fetch_done = (wait_cnt == wait_cnt_t'(`FETCH_WAIT_CYCLES - 1));
    assign exc_done = (wait_cnt == wait_cnt_t'(`EXCEPT_WAIT_CYCLES - 1));

    always_comb begin
        state_next = state;
        case (state)
            ST_FETCH: begin
                if (fetch_done) begin
                    state_next = ST_LATCH;
                end
            end
            ST_LATCH: begin
                state_next = ST_DECODE;
            end
            ST_DECODE: begin
                case (decoded_op)
                    OP_ADD, OP_AND, OP_SUB: begin
                        state_next = ST_EXEC_R;
                    end
                    OP_ADDI: begin
                        state_next = ST_EXEC_I;
                    end
                    default: begin
                        state_next = ST_EXC_OPCODE;
                    end
                endcase
            end
            ST_EXEC_R: begin
                state_next = ov ? ST_EXC_OVERFLOW : ST_WRITE_R;
            end
            ST_EXEC_I: begin
                state_next = ov ? ST_EXC_OVERFLOW : ST_WRITE_I;
            end
            ST_WRITE_R, ST_WRITE_I: begin
                state_next = ST_FETCH;
            end
            ST_EXC_OPCODE, ST_EXC_OVERFLOW: begin
                if (exc_done) begin
                    state_next = ST_EXC_ENTRY;
                end
            end
            ST_EXC_ENTRY: begin
                state_next = ST_FETCH;
            end
            default: begin
                state_next = ST_FETCH;
            end
        endcase
    end

    // Counter clears whenever the next state is not the same wait
    always_comb begin
        if (in_wait && (state_next == state)) begin
            wait_cnt_next = wait_cnt + wait_cnt_t'(1);
        end else begin
            wait_cnt_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_FETCH;
            wait_cnt <= '0;
        end else begin
            state    <= state_next;
            wait_cnt <= wait_cnt_next;
        end
    end

    // Counter is idle outside the wait states
    assert property (@(posedge clk) disable iff (reset)
        !in_wait |-> (wait_cnt == '0));

    assert property (@(posedge clk) disable iff (reset)
        (state == ST_EXC_ENTRY) |=> (state == ST_FETCH));

    assert property (@(posedge clk) disable iff (reset)
        state inside {ST_FETCH, ST_LATCH, ST_DECODE, ST_EXEC_R, ST_EXEC_I,
                      ST_WRITE_R, ST_WRITE_I, ST_EXC_OPCODE, ST_EXC_OVERFLOW,
                      ST_EXC_ENTRY});

endmodule

// ==== design/control_signal_table.sv ====
`timescale 1ns/1ps

module control_signal_table (
    input  control_pkg::ctrl_state_t  state,
    input  control_pkg::decoded_op_t  decoded_op,
    output control_pkg::pc_ctrl_t     pc_ctrl,
    output control_pkg::mem_ctrl_t    mem_ctrl,
    output control_pkg::alu_ctrl_t    alu_ctrl,
    output control_pkg::reg_ctrl_t    reg_ctrl,
    output control_pkg::except_code_t except_code
);

    import control_pkg::*;

    always_comb begin
        pc_ctrl     = '0;
        mem_ctrl    = '0;
        alu_ctrl    = '0;
        reg_ctrl    = '0;
        except_code = EXC_OPCODE;
        case (state)
            ST_FETCH: begin
                // Read strobe while memory answers
                mem_ctrl.mem_wr    = 1'b1;
                mem_ctrl.iord      = ADDR_PC;
                alu_ctrl.alu_src_a = SRC_A_PC;
                alu_ctrl.alu_src_b = SRC_B_FOUR;
                alu_ctrl.alu_op    = ALU_ADD;
            end
            ST_LATCH: begin
                mem_ctrl.iord      = ADDR_PC_HOLD;
                mem_ctrl.ir_write  = 1'b1;
                pc_ctrl.pc_write   = 1'b1;
                pc_ctrl.pc_src     = PC_FROM_ALU;
                alu_ctrl.alu_src_a = SRC_A_PC;
                alu_ctrl.alu_src_b = SRC_B_FOUR;
                alu_ctrl.alu_op    = ALU_ADD;
            end
            ST_DECODE: begin
                // Branch target formed early, operands loaded
                alu_ctrl.a_write   = 1'b1;
                alu_ctrl.b_write   = 1'b1;
                alu_ctrl.alu_src_a = SRC_A_PC;
                alu_ctrl.alu_src_b = SRC_B_BRANCH;
                alu_ctrl.alu_op    = ALU_ADD;
            end
            ST_EXEC_R: begin
                alu_ctrl.alu_src_a     = SRC_A_REG;
                alu_ctrl.alu_src_b     = SRC_B_REG;
                alu_ctrl.alu_out_write = 1'b1;
                case (decoded_op)
                    OP_AND:  alu_ctrl.alu_op = ALU_AND;
                    OP_SUB:  alu_ctrl.alu_op = ALU_SUB;
                    default: alu_ctrl.alu_op = ALU_ADD;
                endcase
            end
            ST_EXEC_I: begin
                alu_ctrl.alu_src_a     = SRC_A_REG;
                alu_ctrl.alu_src_b     = SRC_B_IMM;
                alu_ctrl.alu_op        = ALU_ADD;
                alu_ctrl.alu_out_write = 1'b1;
            end
            ST_WRITE_R: begin
                reg_ctrl.reg_write  = 1'b1;
                reg_ctrl.reg_dst    = DST_RD;
                reg_ctrl.mem_to_reg = WB_ALU_OUT;
            end
            ST_WRITE_I: begin
                reg_ctrl.reg_write  = 1'b1;
                reg_ctrl.reg_dst    = DST_RT;
                reg_ctrl.mem_to_reg = WB_ALU_OUT;
            end
            ST_EXC_OPCODE, ST_EXC_OVERFLOW, ST_EXC_ENTRY: begin
                // PC minus four feeds EPC
                mem_ctrl.iord      = ADDR_EXC_VECTOR;
                alu_ctrl.alu_src_a = SRC_A_PC;
                alu_ctrl.alu_src_b = SRC_B_FOUR;
                alu_ctrl.alu_op    = ALU_SUB;
                // Instruction is still in IR, so the cause follows from it
                except_code = (decoded_op == OP_INVALID) ? EXC_OPCODE : EXC_OVERFLOW;
                if (state == ST_EXC_ENTRY) begin
                    pc_ctrl.epc_write = 1'b1;
                    pc_ctrl.pc_write  = 1'b1;
                    pc_ctrl.pc_src    = PC_FROM_EXC;
                end
            end
            default: begin
                pc_ctrl = '0;
            end
        endcase
    end

    always_comb begin
        assert (!(pc_ctrl.pc_write && reg_ctrl.reg_write))
            else $error("pc_write and reg_write both high");
    end

endmodule

// ==== design/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  control_pkg::opcode_t      opcode,
    input  control_pkg::funct_t       funct,
    input  logic                      ov,
    output control_pkg::pc_ctrl_t     pc_ctrl,
    output control_pkg::mem_ctrl_t    mem_ctrl,
    output control_pkg::alu_ctrl_t    alu_ctrl,
    output control_pkg::reg_ctrl_t    reg_ctrl,
    output control_pkg::except_code_t except_code
);

    import control_pkg::*;

    decoded_op_t decoded_op;
    ctrl_state_t state;

    instr_decoder u_decoder (
        .opcode     (opcode),
        .funct      (funct),
        .decoded_op (decoded_op)
    );

    control_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .decoded_op (decoded_op),
        .ov         (ov),
        .state      (state)
    );

    // Moore outputs straight from the registered state
    control_signal_table u_table (
        .state       (state),
        .decoded_op  (decoded_op),
        .pc_ctrl     (pc_ctrl),
        .mem_ctrl    (mem_ctrl),
        .alu_ctrl    (alu_ctrl),
        .reg_ctrl    (reg_ctrl),
        .except_code (except_code)
    );

endmodule

// ==== testbench/tb_program_table.svh ====
`ifndef TB_PROGRAM_TABLE_SVH
`define TB_PROGRAM_TABLE_SVH

// Columns: opcode, funct, ov, alu_op at execute, reg_dst at writeback,
// exception expected, exception code, cycles to the next ir_write
// funct is randomized by the driver for every non R-type opcode

localparam int prog_len = 16;

localparam prog_entry_t program_table [prog_len] = '{
    '{`R_OPCODE, `FUNCT_ADD, 1'b0, ALU_ADD, DST_RD, 1'b0, EXC_OPCODE,   4'd7},
    '{`R_OPCODE, `FUNCT_AND, 1'b0, ALU_AND, DST_RD, 1'b0, EXC_OPCODE,   4'd7},
    '{`R_OPCODE, `FUNCT_SUB, 1'b0, ALU_SUB, DST_RD, 1'b0, EXC_OPCODE,   4'd7},
    '{`OPC_ADDI, 6'h00,      1'b0, ALU_ADD, DST_RT, 1'b0, EXC_OPCODE,   4'd7},
    // Overflow on add, then back to normal
    '{`R_OPCODE, `FUNCT_ADD, 1'b1, ALU_ADD, DST_RD, 1'b1, EXC_OVERFLOW, 4'd11},
    '{`OPC_ADDI, 6'h00,      1'b0, ALU_ADD, DST_RT, 1'b0, EXC_OPCODE,   4'd7},
    '{`OPC_ADDI, 6'h00,      1'b1, ALU_ADD, DST_RT, 1'b1, EXC_OVERFLOW, 4'd11},
    '{`R_OPCODE, `FUNCT_SUB, 1'b0, ALU_SUB, DST_RD, 1'b0, EXC_OPCODE,   4'd7},
    // Unknown opcode
    '{6'h3f,     6'h00,      1'b0, ALU_NOP, DST_RT, 1'b1, EXC_OPCODE,   4'd10},
    '{`R_OPCODE, `FUNCT_AND, 1'b0, ALU_AND, DST_RD, 1'b0, EXC_OPCODE,   4'd7},
    // div funct is no longer supported
    '{`R_OPCODE, 6'h1a,      1'b0, ALU_NOP, DST_RD, 1'b1, EXC_OPCODE,   4'd10},
    '{`R_OPCODE, `FUNCT_ADD, 1'b0, ALU_ADD, DST_RD, 1'b0, EXC_OPCODE,   4'd7},
    // lw opcode, dropped
    '{6'h23,     6'h00,      1'b0, ALU_NOP, DST_RT, 1'b1, EXC_OPCODE,   4'd10},
    // ov has no effect without an execute cycle
    '{6'h3f,     6'h00,      1'b1, ALU_NOP, DST_RT, 1'b1, EXC_OPCODE,   4'd10},
    '{`R_OPCODE, `FUNCT_SUB, 1'b1, ALU_SUB, DST_RD, 1'b1, EXC_OVERFLOW, 4'd11},
    '{`R_OPCODE, `FUNCT_AND, 1'b0, ALU_AND, DST_RD, 1'b0, EXC_OPCODE,   4'd7}
};

`endif

// ==== testbench/control_unit_tb.sv ====
`timescale 1ns/1ps
`include "control_consts.svh"

module control_unit_tb;

    import control_pkg::*;

    typedef struct packed {
        opcode_t      opcode;
        funct_t       funct;
        logic         ov;
        alu_op_t      exp_alu_op;
        reg_dst_t     exp_reg_dst;
        logic         exp_exc;
        except_code_t exp_code;
        logic [3:0]   exp_cycles;
    } prog_entry_t;

    // Activity seen from one ir_write pulse up to the next
    typedef struct packed {
        logic [7:0]   interval;
        logic [7:0]   rd_cnt;
        logic [7:0]   alu_cnt;
        logic [7:0]   reg_cnt;
        logic [7:0]   epc_cnt;
        logic [7:0]   epc_pc_cnt;
        logic [7:0]   vec_cycles;
        logic [7:0]   a_cnt;
        logic [7:0]   b_cnt;
        logic [7:0]   a_off;
        logic [7:0]   b_off;
        alu_op_t      alu_op;
        alu_src_a_t   src_a;
        alu_src_b_t   src_b;
        reg_dst_t     reg_dst;
        mem_to_reg_t  mem_to_reg;
        except_code_t code;
        logic         code_changed;
    } window_t;

    `include "tb_program_table.svh"

    localparam int timeout_cycles = 50;
    localparam int exc_vec_cycles = `EXCEPT_WAIT_CYCLES + 1;

    logic         clk;
    logic         reset;
    opcode_t      opcode;
    funct_t       funct;
    logic         ov;
    pc_ctrl_t     pc_ctrl;
    mem_ctrl_t    mem_ctrl;
    alu_ctrl_t    alu_ctrl;
    reg_ctrl_t    reg_ctrl;
    except_code_t except_code;

    int      errors;
    int      timeouts;
    int      checks;
    int      cyc;
    int      last_ir_cyc;
    int      ir_seq;
    window_t win;
    window_t snap;

    control_unit uut (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .ov          (ov),
        .pc_ctrl     (pc_ctrl),
        .mem_ctrl    (mem_ctrl),
        .alu_ctrl    (alu_ctrl),
        .reg_ctrl    (reg_ctrl),
        .except_code (except_code)
    );

    always #50 clk = ~clk;

    function automatic logic enables_low();
        return !(pc_ctrl.pc_write || pc_ctrl.epc_write || mem_ctrl.ir_write ||
                 alu_ctrl.a_write || alu_ctrl.b_write || alu_ctrl.alu_out_write ||
                 reg_ctrl.reg_write);
    endfunction

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk) begin
        if (reset) begin
            if (!enables_low()) begin
                $display("ERR %0t: write enable high during reset", $time);
                errors++;
            end
        end else begin
            cyc++;
            if (ir_seq == 0 && !mem_ctrl.ir_write && !enables_low()) begin
                $display("ERR %0t: write enable high in first fetch", $time);
                errors++;
            end
            if (mem_ctrl.mem_wr) begin
                win.rd_cnt = win.rd_cnt + 8'd1;
            end
            if (alu_ctrl.alu_out_write) begin
                win.alu_cnt = win.alu_cnt + 8'd1;
                win.alu_op  = alu_ctrl.alu_op;
                win.src_a   = alu_ctrl.alu_src_a;
                win.src_b   = alu_ctrl.alu_src_b;
            end
            if (reg_ctrl.reg_write) begin
                win.reg_cnt    = win.reg_cnt + 8'd1;
                win.reg_dst    = reg_ctrl.reg_dst;
                win.mem_to_reg = reg_ctrl.mem_to_reg;
            end
            if (pc_ctrl.epc_write) begin
                win.epc_cnt = win.epc_cnt + 8'd1;
                if (pc_ctrl.pc_write && pc_ctrl.pc_src == PC_FROM_EXC) begin
                    win.epc_pc_cnt = win.epc_pc_cnt + 8'd1;
                end
            end
            if (mem_ctrl.iord == ADDR_EXC_VECTOR) begin
                if (win.vec_cycles == 8'd0) begin
                    win.code = except_code;
                end else if (except_code != win.code) begin
                    win.code_changed = 1'b1;
                end
                win.vec_cycles = win.vec_cycles + 8'd1;
            end
            if (alu_ctrl.a_write) begin
                win.a_cnt = win.a_cnt + 8'd1;
                win.a_off = 8'(cyc - last_ir_cyc);
            end
            if (alu_ctrl.b_write) begin
                win.b_cnt = win.b_cnt + 8'd1;
                win.b_off = 8'(cyc - last_ir_cyc);
            end
            if (mem_ctrl.ir_write) begin
                win.interval = 8'(cyc - last_ir_cyc);
                snap = win;
                win = '0;
                last_ir_cyc = cyc;
                ir_seq++;
            end
        end
    end

    task automatic flag_mismatch(input int idx, input string what, input int got, input int want);
        $display("ERR %0t: entry %0d %s is %0d, expected %0d", $time, idx, what, got, want);
        errors++;
    endtask

    task automatic wait_for_ir_write(output logic ok);
        int prev;
        int n;
        prev = ir_seq;
        ok = 1'b0;
        for (n = 0; n < timeout_cycles; n++) begin
            @(posedge clk);
            if (ir_seq != prev) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("Timeout: no ir_write pulse within %0d cycles", timeout_cycles);
            timeouts++;
        end
    endtask

    task automatic apply_entry(input prog_entry_t e);
        opcode <= e.opcode;
        ov     <= e.ov;
        if (e.opcode == `R_OPCODE) begin
            funct <= e.funct;
        end else begin
            funct <= funct_t'($urandom);
        end
    endtask

    task automatic check_entry(input int idx, input prog_entry_t e);
        alu_src_b_t exp_src_b;
        exp_src_b = (e.opcode == `R_OPCODE) ? SRC_B_REG : SRC_B_IMM;
        checks++;
        if (snap.interval != e.exp_cycles) begin
            flag_mismatch(idx, "cycles between ir_write", snap.interval, e.exp_cycles);
        end
        if (snap.rd_cnt != `FETCH_WAIT_CYCLES) begin
            flag_mismatch(idx, "fetch strobe cycles", snap.rd_cnt, `FETCH_WAIT_CYCLES);
        end
        if (snap.a_cnt != 1) begin
            flag_mismatch(idx, "a_write pulses", snap.a_cnt, 1);
        end
        if (snap.b_cnt != 1) begin
            flag_mismatch(idx, "b_write pulses", snap.b_cnt, 1);
        end
        if (snap.a_off != 1) begin
            flag_mismatch(idx, "a_write offset", snap.a_off, 1);
        end
        if (snap.b_off != 1) begin
            flag_mismatch(idx, "b_write offset", snap.b_off, 1);
        end
        if (e.exp_alu_op == ALU_NOP) begin
            if (snap.alu_cnt != 0) begin
                flag_mismatch(idx, "alu_out_write pulses", snap.alu_cnt, 0);
            end
        end else begin
            if (snap.alu_cnt != 1) begin
                flag_mismatch(idx, "alu_out_write pulses", snap.alu_cnt, 1);
            end
            if (snap.alu_op != e.exp_alu_op) begin
                flag_mismatch(idx, "alu_op", snap.alu_op, e.exp_alu_op);
            end
            if (snap.src_a != SRC_A_REG) begin
                flag_mismatch(idx, "alu_src_a", snap.src_a, SRC_A_REG);
            end
            if (snap.src_b != exp_src_b) begin
                flag_mismatch(idx, "alu_src_b", snap.src_b, exp_src_b);
            end
        end
        if (e.exp_exc) begin
            if (snap.reg_cnt != 0) begin
                flag_mismatch(idx, "reg_write pulses", snap.reg_cnt, 0);
            end
            if (snap.epc_cnt != 1) begin
                flag_mismatch(idx, "epc_write pulses", snap.epc_cnt, 1);
            end
            if (snap.epc_pc_cnt != 1) begin
                flag_mismatch(idx, "epc_write with pc_write from EXC", snap.epc_pc_cnt, 1);
            end
            if (snap.vec_cycles != exc_vec_cycles) begin
                flag_mismatch(idx, "exception vector cycles", snap.vec_cycles, exc_vec_cycles);
            end
            if (snap.code != e.exp_code) begin
                flag_mismatch(idx, "except_code", snap.code, e.exp_code);
            end
            if (snap.code_changed) begin
                $display("ERR %0t: entry %0d except_code changed during the exception",
                         $time, idx);
                errors++;
            end
        end else begin
            if (snap.reg_cnt != 1) begin
                flag_mismatch(idx, "reg_write pulses", snap.reg_cnt, 1);
            end
            if (snap.reg_dst != e.exp_reg_dst) begin
                flag_mismatch(idx, "reg_dst", snap.reg_dst, e.exp_reg_dst);
            end
            if (snap.mem_to_reg != WB_ALU_OUT) begin
                flag_mismatch(idx, "mem_to_reg", snap.mem_to_reg, WB_ALU_OUT);
            end
            if (snap.epc_cnt != 0) begin
                flag_mismatch(idx, "epc_write pulses", snap.epc_cnt, 0);
            end
            if (snap.vec_cycles != 0) begin
                flag_mismatch(idx, "exception vector cycles", snap.vec_cycles, 0);
            end
        end
    endtask

    initial begin : main_seq
        int   i;
        logic ok;
        errors      = 0;
        timeouts    = 0;
        checks      = 0;
        cyc         = 0;
        last_ir_cyc = 0;
        ir_seq      = 0;
        win         = '0;
        snap        = '0;
        void'($urandom(32'h6f9c9da8));
        clk    = 1'b0;
        reset  = 1'b1;
        opcode = `R_OPCODE;
        funct  = `FUNCT_ADD;
        ov     = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // First ir_write comes after the fetch wait and the latch cycle
        wait_for_ir_write(ok);
        if (ok) begin
            checks++;
            if (snap.interval != `FETCH_WAIT_CYCLES + 1) begin
                flag_mismatch(-1, "cycles from reset to ir_write", snap.interval,
                              `FETCH_WAIT_CYCLES + 1);
            end
        end

        i = 0;
        while (ok && i < prog_len) begin
            apply_entry(program_table[i]);
            wait_for_ir_write(ok);
            if (ok) begin
                check_entry(i, program_table[i]);
            end
            i++;
        end

        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
+incdir+testbench
design/control_pkg.sv
design/instr_decoder.sv
design/control_fsm.sv
design/control_signal_table.sv
design/control_unit.sv
testbench/control_unit_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
TOP        = control_unit_tb
FILE_LIST  = project.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

# A crash or a nonzero exit also counts as failure
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
